// ==== design/scan_pipe_pkg.sv ====
package scan_pipe_pkg;

    timeunit 1ns;
    timeprecision 1ps;

    // datapath widths shared by every stage of the scan pipeline
    localparam int DATA_WIDTH  = 32;
    localparam int INDEX_WIDTH = 5;    // log2 of DATA_WIDTH
    localparam int TAG_WIDTH   = 4;

    // control that rides beside the lane data through the pipe
    // op is a raw bit here, compared against scan_op_pkg::scan_op_e values
    typedef struct packed {
        logic                 valid;
        logic                 op;
        logic [TAG_WIDTH-1:0] tag;
    } scan_ctl_t;

endpackage

// ==== design/scan_op_pkg.sv ====
package scan_op_pkg;

    timeunit 1ns;
    timeprecision 1ps;

    // bit-scan opcodes
    // BSF scans from bit 0 upward, BSR from the top bit downward
    typedef enum logic {
        SCAN_BSF = 1'b0,
        SCAN_BSR = 1'b1
    } scan_op_e;

    // request as issued by the integer datapath
    typedef struct packed {
        scan_op_e                             op;
        logic [scan_pipe_pkg::TAG_WIDTH-1:0]  tag;     // returned unchanged
        logic [scan_pipe_pkg::DATA_WIDTH-1:0] operand;
    } scan_req_t;

    // result of one scan
    // index is forced to 0 when the operand is zero
    typedef struct packed {
        logic [scan_pipe_pkg::TAG_WIDTH-1:0]   tag;
        logic [scan_pipe_pkg::INDEX_WIDTH-1:0] index;
        logic                                  zero;   // operand had no set bit
    } scan_rsp_t;

endpackage

// ==== design/scan_input_stage.sv ====
module scan_input_stage #(
    parameter int GROUP_WIDTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start,
    input  scan_op_pkg::scan_req_t               req,
    output logic [scan_pipe_pkg::DATA_WIDTH-1:0] lanes,
    output scan_pipe_pkg::scan_ctl_t             ctl
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_GROUPS = scan_pipe_pkg::DATA_WIDTH / GROUP_WIDTH;

    logic [scan_pipe_pkg::DATA_WIDTH-1:0] operand_rev;
    logic [scan_pipe_pkg::DATA_WIDTH-1:0] operand_in;

    // full-word reversal done lane by lane
    // lane g takes the mirrored group, itself reversed bit for bit
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : lane_split
        for (genvar b = 0; b < GROUP_WIDTH; b++) begin : lane_bit
            assign operand_rev[g*GROUP_WIDTH + b] =
                req.operand[(NUM_GROUPS-1-g)*GROUP_WIDTH + (GROUP_WIDTH-1-b)];
        end
    end

    // BSF reuses the highest-bit encoders on the reversed word
    assign operand_in = (req.op == scan_op_pkg::SCAN_BSF) ? operand_rev : req.operand;

    always_ff @(posedge clk) begin
        if (start) begin
            lanes <= operand_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl <= '0;
        end else begin
            ctl.valid <= start;     // one-cycle marker per accepted request
            if (start) begin
                ctl.op  <= req.op;
                ctl.tag <= req.tag;
            end
        end
    end

endmodule

// ==== design/group_priority_encoder.sv ====
module group_priority_encoder #(
    parameter int GROUP_WIDTH = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [GROUP_WIDTH-1:0]         bits,
    output logic [$clog2(GROUP_WIDTH)-1:0] index,
    output logic                           valid
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LOCAL_WIDTH = $clog2(GROUP_WIDTH);

    logic [LOCAL_WIDTH-1:0] index_next;
    logic                   valid_next;

    // upward sweep, so the highest set bit is the last one to write
    always_comb begin
        index_next = '0;    // empty group reports 0
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            if (bits[i]) begin
                index_next = LOCAL_WIDTH'(i);
            end
        end
    end

    assign valid_next = |bits;

    always_ff @(posedge clk) begin
        index <= index_next;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_next;
        end
    end

endmodule

// ==== design/group_combiner.sv ====
module group_combiner #(
    parameter int GROUP_WIDTH = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  scan_pipe_pkg::scan_ctl_t         ctl,
    input  logic [scan_pipe_pkg::DATA_WIDTH/GROUP_WIDTH-1:0] grp_valid,
    input  logic [(scan_pipe_pkg::DATA_WIDTH/GROUP_WIDTH)*$clog2(GROUP_WIDTH)-1:0] grp_index,
    output logic                             done,
    output scan_op_pkg::scan_rsp_t           rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_GROUPS      = scan_pipe_pkg::DATA_WIDTH / GROUP_WIDTH;
    localparam int LOCAL_WIDTH     = $clog2(GROUP_WIDTH);
    localparam int INDEX_WIDTH     = scan_pipe_pkg::INDEX_WIDTH;
    localparam int GROUP_SEL_WIDTH = INDEX_WIDTH - LOCAL_WIDTH;

    scan_pipe_pkg::scan_ctl_t ctl_q;   // aligned with the encoder registers

    logic [GROUP_SEL_WIDTH-1:0] grp_sel;
    logic                       any_valid;
    logic [LOCAL_WIDTH-1:0]     local_index;
    logic [INDEX_WIDTH-1:0]     raw_index;
    logic [INDEX_WIDTH-1:0]     final_index;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl_q <= '0;
        end else begin
            ctl_q <= ctl;
        end
    end

    // second-level priority over the group valid flags
    always_comb begin
        grp_sel = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (grp_valid[g]) begin
                grp_sel = GROUP_SEL_WIDTH'(g);
            end
        end
    end

    assign any_valid   = |grp_valid;
    assign local_index = grp_index[grp_sel*LOCAL_WIDTH +: LOCAL_WIDTH];
    assign raw_index   = {grp_sel, local_index};   // group number is the upper field

    // BSF ran on the reversed word, so mirror back to the true position
    always_comb begin
        if (!any_valid) begin
            final_index = '0;
        end else if (ctl_q.op == scan_op_pkg::SCAN_BSF) begin
            final_index = INDEX_WIDTH'(scan_pipe_pkg::DATA_WIDTH - 1) - raw_index;
        end else begin
            final_index = raw_index;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
            rsp  <= '0;
        end else begin
            done <= ctl_q.valid;
            if (ctl_q.valid) begin
                rsp.tag   <= ctl_q.tag;
                rsp.index <= final_index;
                rsp.zero  <= ~any_valid;
            end
        end
    end

endmodule

// ==== design/bit_scan_unit.sv ====
module bit_scan_unit #(
    parameter int GROUP_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  scan_op_pkg::scan_req_t req,
    output logic                   done,
    output scan_op_pkg::scan_rsp_t rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_GROUPS  = scan_pipe_pkg::DATA_WIDTH / GROUP_WIDTH;
    localparam int LOCAL_WIDTH = $clog2(GROUP_WIDTH);

    logic [scan_pipe_pkg::DATA_WIDTH-1:0] lanes;
    scan_pipe_pkg::scan_ctl_t             ctl;
    logic [NUM_GROUPS-1:0]                grp_valid;
    logic [NUM_GROUPS*LOCAL_WIDTH-1:0]    grp_index;   // local index per group, group 0 lowest

    scan_input_stage #(
        .GROUP_WIDTH(GROUP_WIDTH)
    ) i_input_stage (
        .clk  (clk),
        .rst_n(rst_n),
        .start(start),
        .req  (req),
        .lanes(lanes),
        .ctl  (ctl)
    );

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : group_enc
        group_priority_encoder #(
            .GROUP_WIDTH(GROUP_WIDTH)
        ) i_enc (
            .clk  (clk),
            .rst_n(rst_n),
            .bits (lanes[g*GROUP_WIDTH +: GROUP_WIDTH]),
            .index(grp_index[g*LOCAL_WIDTH +: LOCAL_WIDTH]),
            .valid(grp_valid[g])
        );
    end

    group_combiner #(
        .GROUP_WIDTH(GROUP_WIDTH)
    ) i_combiner (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (ctl),
        .grp_valid(grp_valid),
        .grp_index(grp_index),
        .done     (done),
        .rsp      (rsp)
    );

endmodule

// ==== testbench/scan_vectors.svh ====
`ifndef SCAN_VECTORS_SVH
`define SCAN_VECTORS_SVH

// columns: opcode, operand, idle cycles before issue, expected index, expected zero
localparam int NUM_TABLE_ROWS = 24;

localparam vec_t TABLE_ROWS [NUM_TABLE_ROWS] = '{
    // BSR, highest set bit
    '{scan_op_pkg::SCAN_BSR, 32'h0000_0001, 2'd0, 5'd0,  1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0000_0080, 2'd0, 5'd7,  1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0000_0100, 2'd0, 5'd8,  1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0000_8000, 2'd1, 5'd15, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0001_0000, 2'd0, 5'd16, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h8000_0000, 2'd2, 5'd31, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'hffff_ffff, 2'd0, 5'd31, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0001_8100, 2'd0, 5'd16, 1'b0},   // groups 1 and 2
    '{scan_op_pkg::SCAN_BSR, 32'h00f0_0f00, 2'd1, 5'd23, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h4000_0002, 2'd0, 5'd30, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0300_0040, 2'd0, 5'd25, 1'b0},
    '{scan_op_pkg::SCAN_BSR, 32'h0000_0000, 2'd0, 5'd0,  1'b1},
    // BSF, lowest set bit on the same operands
    '{scan_op_pkg::SCAN_BSF, 32'h0000_0001, 2'd2, 5'd0,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0000_0080, 2'd0, 5'd7,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0000_0100, 2'd0, 5'd8,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0000_8000, 2'd0, 5'd15, 1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0001_0000, 2'd1, 5'd16, 1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h8000_0000, 2'd0, 5'd31, 1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'hffff_ffff, 2'd0, 5'd0,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0001_8100, 2'd0, 5'd8,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h00f0_0f00, 2'd2, 5'd8,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h4000_0002, 2'd0, 5'd1,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0300_0040, 2'd0, 5'd6,  1'b0},
    '{scan_op_pkg::SCAN_BSF, 32'h0000_0000, 2'd0, 5'd0,  1'b1}
};

`endif

// ==== testbench/tb_bit_scan_unit.sv ====
module tb_bit_scan_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH  = scan_pipe_pkg::DATA_WIDTH;
    localparam int INDEX_WIDTH = scan_pipe_pkg::INDEX_WIDTH;
    localparam int TAG_WIDTH   = scan_pipe_pkg::TAG_WIDTH;

    // one stimulus row with its expected result
    typedef struct packed {
        scan_op_pkg::scan_op_e  op;
        logic [DATA_WIDTH-1:0]  operand;
        logic [1:0]             gap;      // idle cycles before issue
        logic [INDEX_WIDTH-1:0] index;
        logic                   zero;
    } vec_t;

    // response still owed by the DUT
    typedef struct packed {
        logic [15:0]            row;
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
        logic                   zero;
        logic [31:0]            issue_edge;
    } exp_t;

    `include "scan_vectors.svh"

    localparam int NUM_RANDOM_ROWS = 64;
    localparam int NUM_ROWS        = NUM_TABLE_ROWS + NUM_RANDOM_ROWS;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    scan_op_pkg::scan_req_t req;
    logic                   done;
    scan_op_pkg::scan_rsp_t rsp;

    logic [31:0] cycle = '0;   // rising edges seen so far
    logic [31:0] lfsr  = 32'h158b_337d;
    vec_t        rows[$];
    exp_t        expected[$];

    bit_scan_unit #(
        .GROUP_WIDTH(8)
    ) i_bit_scan_unit (
        .clk  (clk),
        .rst_n(rst_n),
        .start(start),
        .req  (req),
        .done (done),
        .rsp  (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 32'd1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // direct bit walk, BSR keeps the last hit going up, BSF going down
    function automatic vec_t scan_reference(input scan_op_pkg::scan_op_e op,
                                            input logic [DATA_WIDTH-1:0] operand);
        vec_t row;
        row.op      = op;
        row.operand = operand;
        row.gap     = 2'd0;
        row.index   = '0;
        row.zero    = 1'b1;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            int pos;
            pos = (op == scan_op_pkg::SCAN_BSR) ? i : DATA_WIDTH - 1 - i;
            if (operand[pos]) begin
                row.index = INDEX_WIDTH'(pos);
                row.zero  = 1'b0;
            end
        end
        return row;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // done must match the queue head exactly, including every idle and reset cycle
    always @(negedge clk) begin : response_check
        exp_t head;
        logic exp_done;
        head     = '0;
        exp_done = 1'b0;
        if (expected.size() > 0) begin
            head     = expected[0];
            exp_done = (cycle == head.issue_edge + 32'd2);
        end
        check_value("done", 32'(done), 32'(exp_done));
        if (exp_done) begin
            check_value($sformatf("row %0d tag", head.row), 32'(rsp.tag), 32'(head.tag));
            check_value($sformatf("row %0d index", head.row), 32'(rsp.index), 32'(head.index));
            check_value($sformatf("row %0d zero", head.row), 32'(rsp.zero), 32'(head.zero));
            void'(expected.pop_front());
        end
    end

    initial begin : driver
        logic [31:0] word;
        logic [31:0] shift;
        logic [31:0] op_bit;
        vec_t        row;
        exp_t        entry;
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        for (int r = 0; r < NUM_TABLE_ROWS; r++) begin
            rows.push_back(TABLE_ROWS[r]);
        end
        for (int r = 0; r < NUM_RANDOM_ROWS; r++) begin
            take_bits(32, word);
            take_bits(5, shift);     // spreads the top bit over the word
            take_bits(1, op_bit);
            rows.push_back(scan_reference(scan_op_pkg::scan_op_e'(op_bit[0]),
                                          word >> shift[4:0]));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);   // idle window before the first start
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = rows[r];
            repeat (row.gap) begin
                @(negedge clk);
                start = 1'b0;
            end
            @(negedge clk);
            start          = 1'b1;
            req.op         = row.op;
            req.tag        = TAG_WIDTH'(r % 16);
            req.operand    = row.operand;
            entry.row        = 16'(r);
            entry.tag        = TAG_WIDTH'(r % 16);
            entry.index      = row.index;
            entry.zero       = row.zero;
            entry.issue_edge = cycle + 32'd1;
            expected.push_back(entry);
        end
        @(negedge clk);
        start = 1'b0;
        while (expected.size() > 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);   // no stray done after the last response
        $display("RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_ROWS * 3 + 20) @(posedge clk);
        $display("timed out waiting for responses, %0d still outstanding", expected.size());
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== files.f ====
+incdir+testbench
design/scan_pipe_pkg.sv
design/scan_op_pkg.sv
design/scan_input_stage.sv
design/group_priority_encoder.sv
design/group_combiner.sv
design/bit_scan_unit.sv
testbench/tb_bit_scan_unit.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the bit-scan testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f files.f --top-module tb_bit_scan_unit -o tb_bit_scan_unit \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_bit_scan_unit > sim.log 2>&1
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
